/* Makefile */
# Verilator build for the I2C master testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_master
RTL_TOP   ?= i2c_master_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= \*\*\* TEST PASSED \*\*\*

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/i2c_byte_if.sv */
// I2C byte job interface
`timescale 1ns/1ps
`default_nettype none

interface i2c_byte_if;
    import i2c_pkg::*;

    logic    req;       // job request, four-phase
    logic    ack;       // job finished
    bit_op_t op;
    byte_t   tx_byte;
    byte_t   rx_byte;   // valid while ack is high on reads

    modport producer (
        output req, op, tx_byte,
        input  ack, rx_byte
    );

    modport consumer (
        input  req, op, tx_byte,
        output ack, rx_byte
    );

endinterface

`default_nettype wire

/* common/i2c_pkg.sv */
// I2C master shared definitions
`default_nettype none

package i2c_pkg;

    // --------------------------------------------------
    // bus constants
    // --------------------------------------------------
    localparam logic [6:0] DEV_ADDR         = 7'b1010000; // eeprom device address
    localparam int         QUARTERS_PER_BIT = 4;          // dri_clk cycles per scl bit
    localparam int         BYTE_BITS        = 8;

    typedef logic [BYTE_BITS-1:0] byte_t;
    typedef logic [15:0]          word_addr_t;            // eeprom word address

    // --------------------------------------------------
    // byte jobs for the bit engine
    // --------------------------------------------------
    typedef enum logic [2:0] {
        op_start_byte   = 3'd0,   // start, 8 bits, ack slot
        op_restart_byte = 3'd1,   // repeated start, 8 bits, ack slot
        op_write_byte   = 3'd2,   // 8 bits, ack slot
        op_read_byte    = 3'd3,   // sample 8 bits, then nack
        op_stop         = 3'd4    // stop condition
    } bit_op_t;

    // transaction steps
    typedef enum logic [3:0] {
        st_idle    = 4'd0,
        st_dev_wr  = 4'd1,        // device address, write bit
        st_addr_hi = 4'd2,        // only with 16-bit addressing
        st_addr_lo = 4'd3,
        st_data_wr = 4'd4,
        st_dev_rd  = 4'd5,        // restart, device address, read bit
        st_data_rd = 4'd6,
        st_stop    = 4'd7,
        st_done    = 4'd8         // user ack high
    } seq_state_t;

endpackage

`default_nettype wire

/* flist.f */
common/i2c_pkg.sv
common/i2c_byte_if.sv
i2c_bit_engine/i2c_bit_engine.sv
source/i2c_sequencer.sv
source/i2c_master_top.sv
verification/tb_clock_gen.sv
verification/i2c_eeprom_model.sv
verification/i2c_master_properties.sv
verification/tb_i2c_master.sv

/* i2c_bit_engine/i2c_bit_engine.sv */
// I2C SCL/SDA bit engine
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine (
    input  wire          dri_clk,
    input  wire          rst_n,
    input  wire          sda_in,
    output logic         scl,
    output logic         sda_out,
    output logic         sda_oe,     // 1 drives sda_out onto the bus
    i2c_byte_if.consumer byte_if
);
    import i2c_pkg::*;

    localparam logic [1:0] LAST_QTR = 2'(QUARTERS_PER_BIT - 1);

    logic       busy;                // job past its first cycle
    logic [1:0] qtr;                 // quarter within the bit
    logic [3:0] bit_cnt;             // bit slot within the job
    byte_t      sreg;                // shared tx/rx shift register

    logic       run;
    logic [1:0] qtr_now;
    logic [3:0] slot_now;
    logic [3:0] n_slots;
    logic [3:0] data_idx;
    logic       has_lead;
    logic       lead_slot;
    logic       ack_slot;
    logic       data_slot;
    logic       is_read;
    logic       last_step;
    byte_t      shift_src;

    // --------------------------------------------------
    // step decode
    // --------------------------------------------------
    // first req cycle already acts as quarter 0 of slot 0
    assign run       = busy | (byte_if.req & ~byte_if.ack);
    assign qtr_now   = busy ? qtr : 2'd0;
    assign slot_now  = busy ? bit_cnt : 4'd0;
    assign has_lead  = (byte_if.op == op_start_byte) || (byte_if.op == op_restart_byte);
    assign is_read   = (byte_if.op == op_read_byte);
    assign data_idx  = slot_now - {3'd0, has_lead};
    assign lead_slot = has_lead && (slot_now == 4'd0);
    assign ack_slot  = (data_idx == 4'(BYTE_BITS));
    assign data_slot = (byte_if.op != op_stop) && !lead_slot && !ack_slot;
    assign last_step = (slot_now == n_slots - 4'd1) && (qtr_now == LAST_QTR);
    assign shift_src = (data_idx == 4'd0) ? byte_if.tx_byte : sreg; // msb from tx_byte first
    assign byte_if.rx_byte = sreg;

    always_comb begin
        case (byte_if.op)
            op_start_byte, op_restart_byte: n_slots = 4'(BYTE_BITS + 2);
            op_stop:                        n_slots = 4'd4;  // stop plus bus free time
            default:                        n_slots = 4'(BYTE_BITS + 1);
        endcase
    end

    // step counters and job ack
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            qtr         <= 2'd0;
            bit_cnt     <= 4'd0;
            byte_if.ack <= 1'b0;
        end else if (run) begin
            if (last_step) begin
                busy        <= 1'b0;
                qtr         <= 2'd0;
                bit_cnt     <= 4'd0;
                byte_if.ack <= 1'b1;
            end else begin
                busy    <= 1'b1;
                qtr     <= qtr_now + 2'd1;                 // wraps after quarter 3
                bit_cnt <= (qtr_now == LAST_QTR) ? slot_now + 4'd1 : slot_now;
            end
        end else if (byte_if.ack && !byte_if.req) begin
            byte_if.ack <= 1'b0;
        end
    end

    // --------------------------------------------------
    // pin waveforms
    // --------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_oe  <= 1'b0;
        end else if (run && byte_if.op == op_stop) begin
            case (qtr_now)
                2'd0: if (slot_now == 4'd0) begin
                    sda_oe  <= 1'b1;                       // sda low under scl low
                    sda_out <= 1'b0;
                end
                2'd1: scl <= 1'b1;
                2'd3: if (slot_now == 4'd0) begin
                    sda_oe  <= 1'b0;                       // stop, sda up with scl high
                    sda_out <= 1'b1;
                end
                default: ;
            endcase
        end else if (run) begin
            case (qtr_now)
                2'd0: begin
                    if (lead_slot || (ack_slot && is_read)) begin
                        sda_oe  <= 1'b1;                   // sda high, or master nack
                        sda_out <= 1'b1;
                    end else if (ack_slot || is_read) begin
                        sda_oe  <= 1'b0;                   // slave owns sda
                        sda_out <= 1'b1;
                    end else begin
                        sda_oe  <= 1'b1;
                        sda_out <= shift_src[BYTE_BITS-1];
                    end
                end
                2'd1: scl <= 1'b1;
                2'd2: if (lead_slot) sda_out <= 1'b0;      // start under scl high
                default: scl <= 1'b0;
            endcase
        end
    end

    always_ff @(posedge dri_clk) begin
        if (run && data_slot) begin
            if (!is_read && qtr_now == 2'd0)
                sreg <= {shift_src[BYTE_BITS-2:0], 1'b0};
            else if (is_read && qtr_now == 2'd1)
                sreg <= {sreg[BYTE_BITS-2:0], sda_in};     // sample with scl rise
        end
    end

endmodule

`default_nettype wire

/* source/i2c_master_top.sv */
// I2C EEPROM master top
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top (
    input  wire                      dri_clk,
    input  wire                      rst_n,
    // user side
    input  wire                      i2c_req,
    input  wire                      i2c_rh_wl,    // 1 read, 0 write
    input  wire                      bit_ctrl,     // 1 for 16-bit word address
    input  wire i2c_pkg::word_addr_t i2c_addr,
    input  wire i2c_pkg::byte_t      i2c_data_w,
    output logic                     i2c_ack,
    output i2c_pkg::byte_t           i2c_data_r,
    // bus pins, resolved outside
    output logic                     scl,
    output logic                     sda_out,
    output logic                     sda_oe,
    input  wire                      sda_in
);

    i2c_byte_if u_byte_if ();

    i2c_sequencer u_i2c_sequencer (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_req    (i2c_req),
        .i2c_rh_wl  (i2c_rh_wl),
        .bit_ctrl   (bit_ctrl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .i2c_ack    (i2c_ack),
        .i2c_data_r (i2c_data_r),
        .byte_if    (u_byte_if.producer)
    );

    i2c_bit_engine u_i2c_bit_engine (
        .dri_clk (dri_clk),
        .rst_n   (rst_n),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .byte_if (u_byte_if.consumer)
    );

endmodule

`default_nettype wire

/* source/i2c_sequencer.sv */
// I2C transaction sequencer
`timescale 1ns/1ps
`default_nettype none

module i2c_sequencer (
    input  wire                      dri_clk,
    input  wire                      rst_n,
    input  wire                      i2c_req,
    input  wire                      i2c_rh_wl,
    input  wire                      bit_ctrl,
    input  wire i2c_pkg::word_addr_t i2c_addr,
    input  wire i2c_pkg::byte_t      i2c_data_w,
    output logic                     i2c_ack,
    output i2c_pkg::byte_t           i2c_data_r,
    i2c_byte_if.producer             byte_if
);
    import i2c_pkg::*;

    seq_state_t state;
    seq_state_t next_job;     // step after the current job
    logic       rd_flag;      // latched i2c_rh_wl
    logic       addr16;       // latched bit_ctrl
    word_addr_t addr_q;
    byte_t      data_q;
    logic       job_done;

    assign job_done = byte_if.req & byte_if.ack;

    // --------------------------------------------------
    // job order
    // --------------------------------------------------
    always_comb begin
        case (state)
            st_dev_wr:  next_job = addr16 ? st_addr_hi : st_addr_lo;
            st_addr_hi: next_job = st_addr_lo;
            st_addr_lo: next_job = rd_flag ? st_dev_rd : st_data_wr;
            st_dev_rd:  next_job = st_data_rd;
            st_stop:    next_job = st_done;
            default:    next_job = st_stop;              // after either data byte
        endcase
    end

    // one job per step, held while req is up
    always_comb begin
        byte_if.op      = op_stop;
        byte_if.tx_byte = '0;
        case (state)
            st_dev_wr: begin
                byte_if.op      = op_start_byte;
                byte_if.tx_byte = {DEV_ADDR, 1'b0};      // write bit
            end
            st_addr_hi: begin
                byte_if.op      = op_write_byte;
                byte_if.tx_byte = addr_q[15:8];
            end
            st_addr_lo: begin
                byte_if.op      = op_write_byte;
                byte_if.tx_byte = addr_q[7:0];
            end
            st_data_wr: begin
                byte_if.op      = op_write_byte;
                byte_if.tx_byte = data_q;
            end
            st_dev_rd: begin
                byte_if.op      = op_restart_byte;
                byte_if.tx_byte = {DEV_ADDR, 1'b1};      // read bit
            end
            st_data_rd: byte_if.op = op_read_byte;
            default: ;                                   // stop, or no job
        endcase
    end

    // --------------------------------------------------
    // control FSM with both handshakes
    // --------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            rd_flag     <= 1'b0;
            addr16      <= 1'b0;
            i2c_ack     <= 1'b0;
            byte_if.req <= 1'b0;
        end else begin
            case (state)
                st_idle: if (i2c_req) begin
                    state   <= st_dev_wr;
                    rd_flag <= i2c_rh_wl;
                    addr16  <= bit_ctrl;
                end
                st_done: if (!i2c_req) begin             // user released request
                    i2c_ack <= 1'b0;
                    state   <= st_idle;
                end
                default: begin
                    if (job_done) begin
                        byte_if.req <= 1'b0;
                        state       <= next_job;
                        if (state == st_stop)
                            i2c_ack <= 1'b1;
                    end else if (!byte_if.req && !byte_if.ack) begin
                        byte_if.req <= 1'b1;             // previous ack has fallen
                    end
                end
            endcase
        end
    end

    always_ff @(posedge dri_clk) begin
        if (state == st_idle && i2c_req) begin
            addr_q <= i2c_addr;
            data_q <= i2c_data_w;
        end
    end

    // read result, held until the next read
    always_ff @(posedge dri_clk) begin
        if (state == st_data_rd && job_done)
            i2c_data_r <= byte_if.rx_byte;
    end

endmodule

`default_nettype wire

/* verification/i2c_eeprom_model.sv */
// Behavioral I2C EEPROM slave
`timescale 1ns/1ps
`default_nettype none

module i2c_eeprom_model (
    input  wire         scl,
    input  wire         sda,          // resolved bus
    input  wire         addr16,       // 1 for two word address bytes
    output logic        sda_pull,     // 1 pulls sda low
    output logic [15:0] last_addr
);

    localparam int P_IDLE = 0;
    localparam int P_DEV  = 1;
    localparam int P_AHI  = 2;
    localparam int P_ALO  = 3;
    localparam int P_WR   = 4;
    localparam int P_RD   = 5;

    logic [7:0]  mem [0:65535];
    logic [7:0]  shreg;
    logic [7:0]  rd_byte;
    logic [15:0] addr;
    logic        scl_q;
    logic        sda_q;
    logic        skip_fall;      // falling scl that closes the start slot
    int          phase;
    int          next_phase;
    int          bit_cnt;

    initial begin
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'h00;
        sda_pull   = 1'b0;
        last_addr  = 16'h0000;
        addr       = 16'h0000;
        shreg      = 8'h00;
        rd_byte    = 8'h00;
        phase      = P_IDLE;
        next_phase = P_IDLE;
        bit_cnt    = 0;
        skip_fall  = 1'b0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
    end

    // decide what the completed byte means, returns 1 to ack
    function automatic logic take_byte();
        logic acked;
        acked = 1'b1;
        case (phase)
            P_DEV: begin
                if (shreg[7:1] != 7'b1010000) begin
                    acked      = 1'b0;
                    next_phase = P_IDLE;
                end else if (shreg[0]) begin
                    next_phase = P_RD;
                end else begin
                    next_phase = addr16 ? P_AHI : P_ALO;
                end
            end
            P_AHI: begin
                addr[15:8] = shreg;
                next_phase = P_ALO;
            end
            P_ALO: begin
                addr[7:0] = shreg;
                if (!addr16)
                    addr[15:8] = 8'h00;
                last_addr  = addr;
                next_phase = P_WR;
            end
            P_WR: begin
                mem[addr]  = shreg;
                next_phase = P_WR;
            end
            default: acked = 1'b0;
        endcase
        return acked;
    endfunction

    // --------------------------------------------------
    // bus decode
    // --------------------------------------------------
    always @(scl, sda) begin
        if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            phase     = P_DEV;                           // start or repeated start
            bit_cnt   = 0;
            skip_fall = 1'b1;
            sda_pull  = 1'b0;
        end else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            phase    = P_IDLE;                           // stop
            sda_pull = 1'b0;
        end else if (scl_q === 1'b0 && scl === 1'b1) begin
            if (phase != P_IDLE && phase != P_RD && bit_cnt < 8)
                shreg = {shreg[6:0], sda};               // sample on scl rise
        end else if (scl_q === 1'b1 && scl === 1'b0 && phase != P_IDLE) begin
            if (skip_fall) begin
                skip_fall = 1'b0;
            end else if (bit_cnt < 8) begin
                bit_cnt = bit_cnt + 1;
                if (phase == P_RD)
                    sda_pull = (bit_cnt < 8) ? ~rd_byte[7-bit_cnt] : 1'b0;
                else if (bit_cnt == 8)
                    sda_pull = take_byte();
            end else begin
                // end of the ack slot
                sda_pull = 1'b0;
                bit_cnt  = 0;
                phase    = next_phase;
                if (phase == P_RD) begin
                    rd_byte    = mem[addr];
                    sda_pull   = ~rd_byte[7];
                    next_phase = P_IDLE;                 // master nacks one byte
                end
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

/* verification/i2c_master_properties.sv */
// I2C master bound assertions
`timescale 1ns/1ps
`default_nettype none

module i2c_master_properties (
    input wire       dri_clk,
    input wire       rst_n,
    input wire       i2c_req,
    input wire       i2c_ack,
    input wire       scl,
    input wire       sda_oe,
    input wire [3:0] seq_state,
    input wire       eng_busy,
    input wire [3:0] eng_bit_cnt
);
    import i2c_pkg::*;

    ack_needs_req: assert property (@(posedge dri_clk) disable iff (!rst_n)
        $rose(i2c_ack) |-> $past(i2c_req))
        else $error("i2c_ack rose without i2c_req");

    ack_falls_after_req: assert property (@(posedge dri_clk) disable iff (!rst_n)
        $fell(i2c_ack) |-> !$past(i2c_req))
        else $error("i2c_ack fell while i2c_req was high");

    scl_idle_high: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (seq_state == st_idle) |-> scl)
        else $error("scl low while the sequencer is idle");

    // slave owns sda through the eight read bits
    read_bits_released: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (seq_state == st_data_rd && eng_busy && eng_bit_cnt < 4'd8) |-> !sda_oe)
        else $error("master drives sda during read data bits");

endmodule

bind i2c_master_top i2c_master_properties u_i2c_master_properties (
    .dri_clk     (dri_clk),
    .rst_n       (rst_n),
    .i2c_req     (i2c_req),
    .i2c_ack     (i2c_ack),
    .scl         (scl),
    .sda_oe      (sda_oe),
    .seq_state   (u_i2c_sequencer.state),
    .eng_busy    (u_i2c_bit_engine.busy),
    .eng_bit_cnt (u_i2c_bit_engine.bit_cnt)
);

`default_nettype wire

/* verification/i2c_vectors.txt */
// c r b aaaa dd ee : c check data_r, r read, b 16-bit addr, aaaa addr, dd write data,
// ee expected i2c_data_r after the transaction
00000125a00
1100012005a
0010345a700
00113453c00
111034500a7
1111345003c
11000770000
10000129900
11000120099

/* verification/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic dri_clk,
    output logic rst_n
);

    initial begin
        dri_clk = 1'b0;
        forever #2 dri_clk = ~dri_clk;    // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge dri_clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* verification/tb_i2c_master.sv */
// I2C master testbench
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master;

    localparam int MAX_VECS    = 32;
    localparam int ACK_TIMEOUT = 2000;   // dri_clk cycles per wait

    logic        dri_clk;
    logic        rst_n;
    logic        i2c_req;
    logic        i2c_rh_wl;
    logic        bit_ctrl;
    logic [15:0] i2c_addr;
    logic [7:0]  i2c_data_w;
    logic        i2c_ack;
    logic [7:0]  i2c_data_r;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    logic        model_pull;
    logic [15:0] model_addr;
    wire         sda_bus;

    // c r b aaaa dd ee per line
    logic [43:0] vecs [0:MAX_VECS-1];
    int          errors;
    int          checks;

    assign sda_bus = ~((sda_oe & ~sda_out) | model_pull);   // open drain with pull-up

    tb_clock_gen u_tb_clock_gen (
        .dri_clk (dri_clk),
        .rst_n   (rst_n)
    );

    i2c_master_top u_i2c_master_top (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_req    (i2c_req),
        .i2c_rh_wl  (i2c_rh_wl),
        .bit_ctrl   (bit_ctrl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .i2c_ack    (i2c_ack),
        .i2c_data_r (i2c_data_r),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe),
        .sda_in     (sda_bus)
    );

    i2c_eeprom_model u_i2c_eeprom_model (
        .scl       (scl),
        .sda       (sda_bus),
        .addr16    (bit_ctrl),
        .sda_pull  (model_pull),
        .last_addr (model_addr)
    );

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // wait for i2c_ack to reach level, sampled on the falling edge
    task automatic wait_ack(input logic level, input string what);
        int n;
        n = 0;
        while (i2c_ack !== level) begin
            @(negedge dri_clk);
            n++;
            if (n > ACK_TIMEOUT)
                abort_run(what);
        end
    endtask

    task automatic run_vector(input int idx, input logic [43:0] v);
        string       tag;
        logic [15:0] exp_addr;
        tag      = $sformatf("vec%0d", idx);
        exp_addr = v[32] ? v[31:16] : {8'h00, v[23:16]};
        @(posedge dri_clk);
        i2c_rh_wl  <= v[36];
        bit_ctrl   <= v[32];
        i2c_addr   <= v[31:16];
        i2c_data_w <= v[15:8];
        i2c_req    <= 1'b1;
        @(negedge dri_clk);
        wait_ack(1'b1, {tag, " ack high"});
        // ack must hold while the request stays up
        repeat (8) begin
            @(negedge dri_clk);
            check_value({tag, " ack_held"}, 16'd1, {15'd0, i2c_ack});
        end
        check_value({tag, " word_addr"}, exp_addr, model_addr);
        if (v[40])
            check_value({tag, " data_r"}, {8'h00, v[7:0]}, {8'h00, i2c_data_r});
        @(posedge dri_clk);
        i2c_req <= 1'b0;
        @(negedge dri_clk);
        wait_ack(1'b0, {tag, " ack low"});
    endtask

    initial begin
        int n_vecs;
        int n;
        i2c_req    = 1'b0;
        i2c_rh_wl  = 1'b0;
        bit_ctrl   = 1'b0;
        i2c_addr   = 16'h0000;
        i2c_data_w = 8'h00;
        errors     = 0;
        checks     = 0;
        $readmemh("verification/i2c_vectors.txt", vecs);

        n = 0;
        while (rst_n !== 1'b1) begin
            @(negedge dri_clk);
            n++;
            if (n > 100)
                abort_run("reset release");
        end

        // --------------------------------------------------
        // idle bus after reset
        // --------------------------------------------------
        repeat (4) @(negedge dri_clk);
        check_value("reset scl", 16'd1, {15'd0, scl});
        check_value("reset sda_oe", 16'd0, {15'd0, sda_oe});
        check_value("reset ack", 16'd0, {15'd0, i2c_ack});

        n_vecs = 0;
        while (n_vecs < MAX_VECS && ^vecs[n_vecs] !== 1'bx)
            n_vecs++;
        if (n_vecs == 0) begin
            errors++;
            $display("no vectors were read from the vector file");
        end

        for (int i = 0; i < n_vecs; i++)
            run_vector(i, vecs[i]);

        repeat (10) @(negedge dri_clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
